// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exe_stage -o tb_exe_stage -f vlog.f \
    > sim.log 2>&1 \
    && ./obj_dir/tb_exe_stage >> sim.log 2>&1 \
    || echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0

// File: src/exe_alu.sv
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::alu_op_e         alu_op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    output logic [exe_pkg::xlen-1:0] result,
    output logic                     ov
);
    import exe_pkg::*;

    logic            is_sub;
    logic [xlen-1:0] b_in;
    logic [xlen-1:0] sum;
    logic            carry;
    logic [4:0]      shamt;
    logic            slt_bit;

    // one adder serves add, sub and both compares
    assign is_sub = (alu_op == alu_sub) || (alu_op == alu_subu) ||
                    (alu_op == alu_slt) || (alu_op == alu_sltu);
    assign b_in = is_sub ? ~src2 : src2;
    assign {carry, sum} = {1'b0, src1} + {1'b0, b_in} + {{xlen{1'b0}}, is_sub};

    // signed compare from the sign bits and the difference
    assign slt_bit = (src1[xlen-1] & ~src2[xlen-1]) |
                     (~(src1[xlen-1] ^ src2[xlen-1]) & sum[xlen-1]);

    assign shamt = src1[4:0];

    // operands agree in sign, sum does not
    assign ov = ((alu_op == alu_add) || (alu_op == alu_sub)) &&
                (src1[xlen-1] == b_in[xlen-1]) &&
                (sum[xlen-1] != src1[xlen-1]);

    always_comb begin
        case (alu_op)
            alu_add,
            alu_addu,
            alu_sub,
            alu_subu: result = sum;
            alu_slt:  result = {{(xlen-1){1'b0}}, slt_bit};
            // no carry out means a borrow, so src1 < src2
            alu_sltu: result = {{(xlen-1){1'b0}}, ~carry};
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_nor:  result = ~(src1 | src2);
            alu_sll:  result = src2 << shamt;
            alu_srl:  result = src2 >> shamt;
            alu_sra:  result = $unsigned($signed(src2) >>> shamt);
            alu_lui:  result = {src2[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

// File: src/exe_mem_req.sv
`timescale 1ns/1ps

module exe_mem_req (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       valid,
    input  logic                       commit,
    input  exe_pkg::mem_op_e           mem_op,
    input  logic [exe_pkg::xlen-1:0]   vaddr,
    input  logic [exe_pkg::xlen-1:0]   rt_value,
    input  logic [exe_pkg::asid_w-1:0] asid,
    input  logic                       ov,
    output exe_pkg::sram_req_t         data_sram,
    input  logic                       data_sram_addr_ok,
    output exe_pkg::tlb_query_t        tlb_query,
    input  exe_pkg::tlb_reply_t        tlb_reply,
    output exe_pkg::exc_t              exc,
    output logic                       mem_ready
);
    import exe_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_mem;
    logic       unmapped;
    logic       mapped;
    logic [1:0] low2;
    logic       exc_any;
    logic       req_done;
    logic       accept;

    assign is_load  = (mem_op == mem_lb) || (mem_op == mem_lh) || (mem_op == mem_lw);
    assign is_store = (mem_op == mem_sb) || (mem_op == mem_sh) || (mem_op == mem_sw);
    assign is_mem   = is_load || is_store;
    assign low2     = vaddr[1:0];

    // 0x8 to 0xb in the top nibble bypass the TLB
    assign unmapped = (vaddr[xlen-1:xlen-2] == 2'b10);
    assign mapped   = is_mem && !unmapped;

    assign tlb_query = '{vpn2: vaddr[31:13], odd_page: vaddr[12], asid: asid};

    always_comb begin
        exc.ov        = ov;
        exc.ades      = ((mem_op == mem_sh) && low2[0]) ||
                        ((mem_op == mem_sw) && (low2 != 2'b00));
        exc.refill_l  = mapped && is_load && !tlb_reply.found;
        exc.refill_s  = mapped && is_store && !tlb_reply.found;
        exc.invalid_l = mapped && is_load && tlb_reply.found && !tlb_reply.v;
        exc.invalid_s = mapped && is_store && tlb_reply.found && !tlb_reply.v;
        // store hit on a clean valid page
        exc.modified  = mapped && is_store && tlb_reply.found && tlb_reply.v && !tlb_reply.d;
    end

    assign exc_any = (exc != '0);

    always_comb begin
        data_sram.req  = valid && is_mem && !exc_any && !req_done && !flush;
        data_sram.wr   = is_store;
        data_sram.addr = unmapped ? (vaddr & unmapped_mask) : {tlb_reply.pfn, vaddr[11:0]};
        case (mem_op)
            mem_lb,
            mem_sb: begin
                data_sram.size  = 2'd0;
                data_sram.wdata = {4{rt_value[7:0]}};
            end
            mem_lh,
            mem_sh: begin
                data_sram.size  = 2'd1;
                data_sram.wdata = {2{rt_value[15:0]}};
            end
            default: begin
                data_sram.size  = 2'd2;
                data_sram.wdata = rt_value;
            end
        endcase
        case (mem_op)
            mem_sb:  data_sram.wstrb = 4'b0001 << low2;
            mem_sh:  data_sram.wstrb = 4'b0011 << low2;
            mem_sw:  data_sram.wstrb = 4'b1111;
            default: data_sram.wstrb = 4'b0000;
        endcase
    end

    assign accept = data_sram.req && data_sram_addr_ok;

    // one request per instruction, even while the stage is held
    always_ff @(posedge clk) begin
        if (reset || flush || commit) begin
            req_done <= 1'b0;
        end else if (accept) begin
            req_done <= 1'b1;
        end
    end

    assign mem_ready = !is_mem || exc_any || req_done || accept;

endmodule

// File: src/exe_muldiv.sv
`timescale 1ns/1ps

module exe_muldiv (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     issue,
    input  logic                     commit,
    input  exe_pkg::md_op_e          md_op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    output logic                     busy,
    output logic [exe_pkg::xlen-1:0] hi_lo_result
);
    import exe_pkg::*;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_e;

    div_state_e               state;
    logic [4:0]               step;
    logic [xlen-1:0]          hi;
    logic [xlen-1:0]          lo;
    logic [xlen-1:0]          quo;
    logic [xlen-1:0]          rem;
    logic [xlen-1:0]          dvs;
    logic                     q_neg;
    logic                     r_neg;
    logic                     is_div;
    logic                     is_signed_div;
    logic [xlen-1:0]          mag1;
    logic [xlen-1:0]          mag2;
    logic [xlen:0]            trial;
    logic [xlen-1:0]          quo_fix;
    logic [xlen-1:0]          rem_fix;
    logic signed [2*xlen-1:0] prod_s;
    logic [2*xlen-1:0]        prod_u;

    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = {{xlen{1'b0}}, src1} * {{xlen{1'b0}}, src2};

    assign is_div        = (md_op == md_div) || (md_op == md_divu);
    assign is_signed_div = (md_op == md_div);

    // divider works on magnitudes
    assign mag1 = (is_signed_div && src1[xlen-1]) ? -src1 : src1;
    assign mag2 = (is_signed_div && src2[xlen-1]) ? -src2 : src2;

    // shifted partial remainder minus divisor, bit xlen set means negative
    assign trial = {rem, quo[xlen-1]} - {1'b0, dvs};

    assign quo_fix = q_neg ? -quo : quo;
    assign rem_fix = r_neg ? -rem : rem;

    // stays high from the first valid cycle until the quotient is ready
    assign busy = issue && is_div && (state != div_done);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= div_idle;
        end else begin
            case (state)
                div_idle: begin
                    if (issue && is_div) begin
                        state <= div_run;
                    end
                end
                div_run: begin
                    if (step == 5'd31) begin
                        state <= div_done;
                    end
                end
                div_done: begin
                    if (commit) begin
                        state <= div_idle;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    // idle keeps reloading so the start edge captures the operands
    always_ff @(posedge clk) begin
        if (state == div_idle) begin
            step  <= '0;
            quo   <= mag1;
            rem   <= '0;
            dvs   <= mag2;
            q_neg <= is_signed_div && (src1[xlen-1] ^ src2[xlen-1]);
            r_neg <= is_signed_div && src1[xlen-1];
        end else if (state == div_run) begin
            step <= step + 5'd1;
            if (!trial[xlen]) begin
                rem <= trial[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= {rem[xlen-2:0], quo[xlen-1]};
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    // hi/lo only move when the instruction retires cleanly
    always_ff @(posedge clk) begin
        if (commit) begin
            case (md_op)
                md_mult: begin
                    hi <= prod_s[2*xlen-1:xlen];
                    lo <= prod_s[xlen-1:0];
                end
                md_multu: begin
                    hi <= prod_u[2*xlen-1:xlen];
                    lo <= prod_u[xlen-1:0];
                end
                md_div,
                md_divu: begin
                    hi <= rem_fix;
                    lo <= quo_fix;
                end
                md_mthi: hi <= src1;
                md_mtlo: lo <= src1;
                default: ;
            endcase
        end
    end

    assign hi_lo_result = (md_op == md_mfhi) ? hi : lo;

endmodule

// File: src/exe_pkg.sv
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int vpn2_w     = 19;
    localparam int pfn_w      = 20;
    localparam int asid_w     = 8;

    // kseg0/kseg1 keep only the low 29 bits
    localparam logic [xlen-1:0] unmapped_mask = 32'h1fff_ffff;

    typedef enum logic [3:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        md_none,
        md_mult,
        md_multu,
        md_div,
        md_divu,
        md_mfhi,
        md_mflo,
        md_mthi,
        md_mtlo
    } md_op_e;

    typedef enum logic [2:0] {
        mem_none,
        mem_lb,
        mem_lh,
        mem_lw,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_imm,
        src2_const8
    } src2_sel_e;

    // imm arrives already extended by decode
    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        md_op_e                md_op;
        mem_op_e               mem_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       rs_value;
        logic [xlen-1:0]       rt_value;
    } ds_to_es_t;

    typedef struct packed {
        logic ov;
        logic ades;
        logic refill_l;
        logic refill_s;
        logic invalid_l;
        logic invalid_s;
        logic modified;
    } exc_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        mem_op_e               mem_op;
        logic [1:0]            addr_low2;
        exc_t                  exc;
    } es_to_ms_t;

    typedef struct packed {
        logic            req;
        logic            wr;
        logic [1:0]      size;
        logic [3:0]      wstrb;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic              odd_page;
        logic [asid_w-1:0] asid;
    } tlb_query_t;

    typedef struct packed {
        logic             found;
        logic [pfn_w-1:0] pfn;
        logic             d;
        logic             v;
    } tlb_reply_t;

endpackage

// File: src/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       ds_to_es_valid,
    input  exe_pkg::ds_to_es_t         ds_to_es_bus,
    output logic                       es_allowin,
    input  logic                       ms_allowin,
    output logic                       es_to_ms_valid,
    output exe_pkg::es_to_ms_t         es_to_ms_bus,
    output exe_pkg::sram_req_t         data_sram,
    input  logic                       data_sram_addr_ok,
    output exe_pkg::tlb_query_t        tlb_query,
    input  exe_pkg::tlb_reply_t        tlb_reply,
    input  logic [exe_pkg::asid_w-1:0] asid
);
    import exe_pkg::*;

    logic            es_valid;
    ds_to_es_t       ds_r;
    logic            es_ready_go;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic            alu_ov;
    logic [xlen-1:0] hi_lo_result;
    logic [xlen-1:0] es_result;
    logic            md_busy;
    logic            mem_ready;
    exc_t            exc;
    logic            exc_any;
    logic            commit;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_r <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (ds_r.src1_sel)
            src1_sa: alu_src1 = {{(xlen-5){1'b0}}, ds_r.imm[10:6]};
            src1_pc: alu_src1 = ds_r.pc;
            default: alu_src1 = ds_r.rs_value;
        endcase
        case (ds_r.src2_sel)
            src2_imm:    alu_src2 = ds_r.imm;
            src2_const8: alu_src2 = 32'd8;
            default:     alu_src2 = ds_r.rt_value;
        endcase
    end

    exe_alu u_alu (
        .alu_op (ds_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result),
        .ov     (alu_ov)
    );

    exe_muldiv u_muldiv (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue        (es_valid),
        .commit       (commit),
        .md_op        (ds_r.md_op),
        .src1         (alu_src1),
        .src2         (alu_src2),
        .busy         (md_busy),
        .hi_lo_result (hi_lo_result)
    );

    exe_mem_req u_mem_req (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .valid             (es_valid),
        .commit            (commit),
        .mem_op            (ds_r.mem_op),
        .vaddr             (alu_result),
        .rt_value          (ds_r.rt_value),
        .asid              (asid),
        .ov                (alu_ov),
        .data_sram         (data_sram),
        .data_sram_addr_ok (data_sram_addr_ok),
        .tlb_query         (tlb_query),
        .tlb_reply         (tlb_reply),
        .exc               (exc),
        .mem_ready         (mem_ready)
    );

    assign exc_any     = (exc != '0);
    assign es_ready_go = !md_busy && mem_ready;

    // a flushed instruction never reaches the memory stage
    assign es_to_ms_valid = es_valid && es_ready_go && !flush;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign commit         = es_to_ms_valid && ms_allowin && !exc_any;

    assign es_result = ((ds_r.md_op == md_mfhi) || (ds_r.md_op == md_mflo)) ?
                       hi_lo_result : alu_result;

    assign es_to_ms_bus = '{pc:        ds_r.pc,
                            result:    es_result,
                            dest:      ds_r.dest,
                            gr_we:     ds_r.gr_we,
                            mem_op:    ds_r.mem_op,
                            addr_low2: alu_result[1:0],
                            exc:       exc};

endmodule

// File: testbench/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage;
    import exe_pkg::*;

    logic              clk;
    logic              reset;
    logic              flush;
    logic              ds_to_es_valid;
    ds_to_es_t         ds_to_es_bus;
    logic              es_allowin;
    logic              ms_allowin = 1'b1;
    logic              es_to_ms_valid;
    es_to_ms_t         es_to_ms_bus;
    sram_req_t         data_sram;
    logic              data_sram_addr_ok = 1'b0;
    tlb_query_t        tlb_query;
    tlb_reply_t        tlb_reply;
    logic [asid_w-1:0] asid;

    // instructions currently held by the stage, at most one
    ds_to_es_t       in_stage[$];
    logic [xlen-1:0] model_hi;
    logic [xlen-1:0] model_lo;
    int              req_count;
    int              issued;
    int              cycles;
    int              ok_wait;
    logic            stall_mode;
    logic            hold_ms;
    logic            held;
    es_to_ms_t       held_bus;

    exe_stage UUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fail_check(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "check failed");
    endtask

    // small fixed TLB, outcome picked by the low vpn2 bits
    function automatic tlb_reply_t tlb_lookup(input logic [vpn2_w-1:0] vpn2);
        tlb_reply_t r;
        r.found = (vpn2[2:0] != 3'd7);
        r.v     = (vpn2[2:0] != 3'd6);
        r.d     = (vpn2[2:0] != 3'd5);
        r.pfn   = {1'b0, vpn2} + 20'h0_4000;
        return r;
    endfunction

    always_comb tlb_reply = tlb_lookup(tlb_query.vpn2);

    function automatic logic [xlen-1:0] op1(input ds_to_es_t d);
        case (d.src1_sel)
            src1_sa: return {27'd0, d.imm[10:6]};
            src1_pc: return d.pc;
            default: return d.rs_value;
        endcase
    endfunction

    function automatic logic [xlen-1:0] op2(input ds_to_es_t d);
        case (d.src2_sel)
            src2_imm:    return d.imm;
            src2_const8: return 32'd8;
            default:     return d.rt_value;
        endcase
    endfunction

    function automatic logic [xlen-1:0] alu_ref(input ds_to_es_t d);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = op1(d);
        b = op2(d);
        case (d.alu_op)
            alu_add, alu_addu: return a + b;
            alu_sub, alu_subu: return a - b;
            alu_slt:  return {31'd0, $signed(a) < $signed(b)};
            alu_sltu: return {31'd0, a < b};
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return b << a[4:0];
            alu_srl:  return b >> a[4:0];
            alu_sra:  return $unsigned($signed(b) >>> a[4:0]);
            default:  return {b[15:0], 16'h0000};
        endcase
    endfunction

    function automatic exc_t exc_ref(input ds_to_es_t d);
        exc_t            e;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] va;
        tlb_reply_t      t;
        logic            ld;
        logic            st;
        logic            mp;
        a  = op1(d);
        b  = op2(d);
        va = alu_ref(d);
        t  = tlb_lookup(va[31:13]);
        ld = (d.mem_op == mem_lb) || (d.mem_op == mem_lh) || (d.mem_op == mem_lw);
        st = (d.mem_op == mem_sb) || (d.mem_op == mem_sh) || (d.mem_op == mem_sw);
        mp = (ld || st) && (va[31:30] != 2'b10);
        e  = '0;
        // signed overflow from operand and result signs
        if (d.alu_op == alu_add) begin
            e.ov = (a[31] == b[31]) && (va[31] != a[31]);
        end else if (d.alu_op == alu_sub) begin
            e.ov = (a[31] != b[31]) && (va[31] != a[31]);
        end
        e.ades = ((d.mem_op == mem_sh) && va[0]) ||
                 ((d.mem_op == mem_sw) && (va[1:0] != 2'b00));
        if (mp && !t.found) begin
            e.refill_l = ld;
            e.refill_s = st;
        end else if (mp && !t.v) begin
            e.invalid_l = ld;
            e.invalid_s = st;
        end else if (mp && st && !t.d) begin
            e.modified = 1'b1;
        end
        return e;
    endfunction

    task automatic update_hilo(input ds_to_es_t d);
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic [xlen-1:0]   ma;
        logic [xlen-1:0]   mb;
        logic [2*xlen-1:0] p;
        a  = op1(d);
        b  = op2(d);
        ma = a[31] ? -a : a;
        mb = b[31] ? -b : b;
        case (d.md_op)
            md_mult: begin
                p = $signed({{xlen{a[31]}}, a}) * $signed({{xlen{b[31]}}, b});
                {model_hi, model_lo} = p;
            end
            md_multu: begin
                p = {32'd0, a} * {32'd0, b};
                {model_hi, model_lo} = p;
            end
            md_div: begin
                // quotient sign from both operands, remainder from the dividend
                model_lo = (a[31] ^ b[31]) ? -(ma / mb) : (ma / mb);
                model_hi = a[31] ? -(ma % mb) : (ma % mb);
            end
            md_divu: begin
                model_lo = a / b;
                model_hi = a % b;
            end
            md_mthi: model_hi = a;
            md_mtlo: model_lo = a;
            default: ;
        endcase
    endtask

    task automatic check_request();
        ds_to_es_t       d;
        logic [xlen-1:0] va;
        tlb_reply_t      t;
        sram_req_t       e;
        assert (in_stage.size() == 1) else fail_check("memory request with an empty stage");
        d  = in_stage[0];
        va = alu_ref(d);
        t  = tlb_lookup(va[31:13]);
        e.req  = 1'b1;
        e.wr   = (d.mem_op == mem_sb) || (d.mem_op == mem_sh) || (d.mem_op == mem_sw);
        e.addr = (va[31:30] == 2'b10) ? (va & 32'h1fff_ffff) : {t.pfn, va[11:0]};
        case (d.mem_op)
            mem_lb, mem_sb: begin
                e.size  = 2'd0;
                e.wdata = {4{d.rt_value[7:0]}};
            end
            mem_lh, mem_sh: begin
                e.size  = 2'd1;
                e.wdata = {2{d.rt_value[15:0]}};
            end
            default: begin
                e.size  = 2'd2;
                e.wdata = d.rt_value;
            end
        endcase
        case (d.mem_op)
            mem_sb:  e.wstrb = 4'b0001 << va[1:0];
            mem_sh:  e.wstrb = 4'b0011 << va[1:0];
            mem_sw:  e.wstrb = 4'b1111;
            default: e.wstrb = 4'b0000;
        endcase
        assert (data_sram == e)
            else fail_check($sformatf("request %h, expected %h", data_sram, e));
        req_count++;
    endtask

    task automatic check_transfer();
        ds_to_es_t       d;
        es_to_ms_t       e;
        tlb_query_t      q;
        logic [xlen-1:0] va;
        int              want_req;
        assert (in_stage.size() == 1) else fail_check("transfer with no instruction expected");
        d  = in_stage.pop_front();
        va = alu_ref(d);
        e.pc        = d.pc;
        e.dest      = d.dest;
        e.gr_we     = d.gr_we;
        e.mem_op    = d.mem_op;
        e.addr_low2 = va[1:0];
        e.exc       = exc_ref(d);
        if (d.md_op == md_mfhi) begin
            e.result = model_hi;
        end else if (d.md_op == md_mflo) begin
            e.result = model_lo;
        end else begin
            e.result = va;
        end
        assert (es_to_ms_bus == e)
            else fail_check($sformatf("output bus %h, expected %h", es_to_ms_bus, e));
        // lookup key is the virtual page pair, the page within it and the asid
        if (d.mem_op != mem_none) begin
            q.vpn2     = va[31:13];
            q.odd_page = va[12];
            q.asid     = asid;
            assert (tlb_query == q)
                else fail_check($sformatf("TLB query %h, expected %h", tlb_query, q));
        end
        want_req = ((d.mem_op != mem_none) && (e.exc == '0)) ? 1 : 0;
        assert (req_count == want_req)
            else fail_check($sformatf("%0d requests, expected %0d", req_count, want_req));
        req_count = 0;
        if (e.exc == '0) begin
            update_hilo(d);
        end
    endtask

    function automatic logic stage_idle();
        return !es_to_ms_valid && es_allowin && !data_sram.req;
    endfunction

    // transfer, request and back-pressure checks
    always @(posedge clk) begin
        if (!reset) begin
            if (held && !flush) begin
                assert (es_to_ms_valid && (es_to_ms_bus == held_bus))
                    else fail_check("output changed while held by the memory stage");
            end
            if (es_to_ms_valid && !ms_allowin) begin
                assert (!es_allowin) else fail_check("es_allowin high while held");
            end
            held     = es_to_ms_valid && !ms_allowin && !flush;
            held_bus = es_to_ms_bus;
            if (data_sram.req && data_sram_addr_ok) begin
                check_request();
            end
            if (flush) begin
                in_stage.delete();
                req_count = 0;
            end else if (es_to_ms_valid && ms_allowin) begin
                check_transfer();
            end
            if (ds_to_es_valid && es_allowin && !flush) begin
                in_stage.push_back(ds_to_es_bus);
            end
        end
    end

    // memory accepts after a short random wait
    always @(posedge clk) begin
        if (reset || !data_sram.req || data_sram_addr_ok) begin
            data_sram_addr_ok <= 1'b0;
            ok_wait <= $urandom_range(0, 3);
        end else if (ok_wait == 0) begin
            data_sram_addr_ok <= 1'b1;
        end else begin
            ok_wait <= ok_wait - 1;
        end
    end

    always @(posedge clk) begin
        if (hold_ms) begin
            ms_allowin <= 1'b0;
        end else if (stall_mode) begin
            ms_allowin <= ($urandom_range(0, 2) != 0);
        end else begin
            ms_allowin <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * (issued + 1)) begin
            $display("Timeout: the stage stopped making progress after %0d cycles", cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [xlen-1:0] rand_value();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic ds_to_es_t blank_instr();
        ds_to_es_t d;
        d.pc       = $urandom & 32'hffff_fffc;
        d.alu_op   = alu_addu;
        d.md_op    = md_none;
        d.mem_op   = mem_none;
        d.src1_sel = src1_rs;
        d.src2_sel = src2_rt;
        d.gr_we    = 1'($urandom_range(0, 1));
        d.dest     = 5'($urandom_range(0, 31));
        d.imm      = rand_value();
        d.rs_value = rand_value();
        d.rt_value = rand_value();
        return d;
    endfunction

    function automatic ds_to_es_t alu_instr();
        ds_to_es_t  d;
        logic [3:0] k;
        logic [1:0] s1;
        logic [1:0] s2;
        d  = blank_instr();
        k  = 4'($urandom_range(0, 13));
        s1 = 2'($urandom_range(0, 2));
        s2 = 2'($urandom_range(0, 2));
        d.alu_op   = alu_op_e'(k);
        d.src1_sel = src1_sel_e'(s1);
        d.src2_sel = src2_sel_e'(s2);
        return d;
    endfunction

    function automatic ds_to_es_t md_instr(input md_op_e op);
        ds_to_es_t d;
        d = blank_instr();
        d.md_op = op;
        if (((op == md_div) || (op == md_divu)) && (d.rt_value == 32'd0)) begin
            d.rt_value = 32'd1;
        end
        return d;
    endfunction

    function automatic ds_to_es_t mem_instr();
        ds_to_es_t  d;
        logic [2:0] k;
        d = blank_instr();
        k = 3'($urandom_range(1, 6));
        d.mem_op   = mem_op_e'(k);
        d.src2_sel = src2_imm;
        d.rs_value = $urandom;
        // half the accesses go to the unmapped window
        if ($urandom_range(0, 1) == 0) begin
            d.rs_value[31:30] = 2'b10;
        end else if (d.rs_value[31:30] == 2'b10) begin
            d.rs_value[30] = 1'b1;
        end
        d.imm = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
        if ($urandom_range(0, 3) != 0) begin
            d.rs_value[1:0] = 2'b00;
        end
        return d;
    endfunction

    task automatic issue(input ds_to_es_t d);
        ds_to_es_valid <= 1'b1;
        ds_to_es_bus   <= d;
        asid           <= asid_w'($urandom);
        issued++;
        do @(posedge clk); while (!es_allowin);
        ds_to_es_valid <= 1'b0;
    endtask

    initial begin
        ds_to_es_t d;
        void'($urandom(32'h1c95_3991));
        reset          = 1'b1;
        flush          = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        asid           = 8'h3c;
        stall_mode     = 1'b0;
        hold_ms        = 1'b0;
        held           = 1'b0;
        req_count      = 0;
        issued         = 0;
        cycles         = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (stage_idle()) else fail_check("stage not idle after reset");
        @(posedge clk);

        // hi/lo get known values first
        issue(md_instr(md_mthi));
        issue(md_instr(md_mtlo));
        issue(md_instr(md_mfhi));
        issue(md_instr(md_mflo));
        repeat (60) issue(alu_instr());

        // overflowing instructions must leave hi/lo alone
        d = md_instr(md_mthi);
        d.alu_op   = alu_add;
        d.rs_value = 32'h7fff_ffff;
        d.rt_value = 32'h0000_0001;
        issue(d);
        issue(md_instr(md_mfhi));
        d = md_instr(md_mtlo);
        d.alu_op   = alu_sub;
        d.rs_value = 32'h8000_0000;
        d.rt_value = 32'h0000_0001;
        issue(d);
        issue(md_instr(md_mflo));

        repeat (6) begin
            issue(md_instr(md_mult));
            issue(md_instr(md_mfhi));
            issue(md_instr(md_mflo));
            issue(md_instr(md_multu));
            issue(md_instr(md_mfhi));
            issue(md_instr(md_mflo));
            issue(md_instr(md_div));
            issue(md_instr(md_mfhi));
            issue(md_instr(md_mflo));
            issue(md_instr(md_divu));
            issue(md_instr(md_mfhi));
            issue(md_instr(md_mflo));
        end
        repeat (80) issue(mem_instr());

        // random back-pressure over a mix
        stall_mode <= 1'b1;
        repeat (90) begin
            case ($urandom_range(0, 2))
                0:       issue(alu_instr());
                1:       issue(mem_instr());
                default: issue(md_instr(md_op_e'(4'($urandom_range(1, 8)))));
            endcase
        end
        stall_mode <= 1'b0;

        // flush a held instruction, starting from an empty stage
        do @(negedge clk); while (in_stage.size() != 0);
        @(posedge clk);
        hold_ms <= 1'b1;
        @(posedge clk);
        issue(mem_instr());
        do @(posedge clk); while (!es_to_ms_valid);
        flush <= 1'b1;
        @(posedge clk);
        flush   <= 1'b0;
        hold_ms <= 1'b0;

        // flush a divide in progress
        issue(md_instr(md_div));
        repeat (5) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        issue(md_instr(md_mfhi));
        issue(md_instr(md_mflo));

        repeat (2) @(posedge clk);
        do @(negedge clk); while (in_stage.size() != 0);
        repeat (4) @(negedge clk);
        if (!stage_idle()) begin
            $display("Stage not idle at the end of the run");
            $display("Test failures found");
            $fatal(1, "stage not idle");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: vlog.f
src/exe_pkg.sv
src/exe_alu.sv
src/exe_muldiv.sv
src/exe_mem_req.sv
src/exe_stage.sv
testbench/tb_exe_stage.sv
